/* design/lq_pkg.sv */
// load queue entry shared definitions
// id and byte mask types, line offset and id age compare

package lq_pkg;

  //======================================================================
  // instruction id
  //======================================================================
  // msb is the wrap flag, low bits the sequence number
  localparam int IID_W = 7;

  typedef logic [IID_W-1:0] iid_t;

  //======================================================================
  // cache line geometry
  //======================================================================
  // one valid bit per byte of a 16 byte line
  localparam int BYTES_W = 16;

  typedef logic [BYTES_W-1:0] bytes_t;

  // offset bits below the stored line index
  localparam int LINE_OFFS = 4;

  // true when id a is older than id b
  function automatic logic iid_older(input iid_t a, input iid_t b);
    logic same_wrap;
    logic older;
    same_wrap = (a[IID_W-1] == b[IID_W-1]);
    // same lap, smaller sequence is older
    if (same_wrap)
    begin
      older = (a[IID_W-2:0] < b[IID_W-2:0]);
    end
    // id counter wrapped between them, larger sequence is older
    else
    begin
      older = (a[IID_W-2:0] > b[IID_W-2:0]);
    end
    return older;
  endfunction

endpackage

/* design/lq_entry_if.sv */
// load queue entry contents
// registered entry state from storage to the speculation checkers
`timescale 1ns/100ps

interface lq_entry_if #(
  parameter int PA_WIDTH = 40
);
  import lq_pkg::*;

  // entry holds a live load
  logic                          vld;
  // id of the queued load
  iid_t                          iid;
  // entry came from the second half of a split load
  logic                          secd;
  // physical line index, address above the line offset
  logic [PA_WIDTH-LINE_OFFS-1:0] line;
  // bytes already read by the queued load
  bytes_t                        bytes;

  // storage side drives the contents
  modport store (output vld, iid, secd, line, bytes);
  // checkers only look
  modport check (input vld, iid, secd, line, bytes);

endinterface

/* design/lq_entry_store.sv */
// load queue entry storage
// valid bit and data registers of one queued load,
// commit release and instance hit lookup
`timescale 1ns/100ps

module lq_entry_store #(
  parameter int PA_WIDTH = 40
) (
  input  logic                lq_clk,
  input  logic                cpurst_b,
  input  logic                create0_vld,
  input  logic                create1_vld,
  input  logic                create0_dp_vld,
  input  logic                create1_dp_vld,
  input  logic [PA_WIDTH-1:0] ld_addr0,
  input  logic [PA_WIDTH-1:0] ld_addr1,
  input  lq_pkg::bytes_t      ld_bytes_vld,
  input  lq_pkg::bytes_t      ld_bytes_vld1,
  input  lq_pkg::iid_t        ld_iid,
  input  logic                ld_secd,
  input  logic                commit0,
  input  logic                commit1,
  input  logic                commit2,
  input  lq_pkg::iid_t        commit0_iid,
  input  lq_pkg::iid_t        commit1_iid,
  input  lq_pkg::iid_t        commit2_iid,
  input  logic                flush,
  output logic                inst_hit,
  lq_entry_if.store           ent
);
  import lq_pkg::*;

  localparam int LINE_W = PA_WIDTH - LINE_OFFS;

  logic              entry_vld;
  iid_t              entry_iid;
  logic              entry_secd;
  logic [LINE_W-1:0] entry_line;
  bytes_t            entry_bytes;

  logic              create_vld;
  logic              cmit_hit0;
  logic              cmit_hit1;
  logic              cmit_hit2;
  logic              pop_vld;

  //======================================================================
  // entry valid
  //======================================================================
  // either load pipe slot may allocate
  assign create_vld = create0_vld | create1_vld;

  // pop and flush win over a same cycle create
  always_ff @(posedge lq_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (pop_vld || flush)
      entry_vld <= 1'b0;
    else if (create_vld)
      entry_vld <= 1'b1;
  end

  //======================================================================
  // entry data
  //======================================================================
  // slot 0 first, slot 1 only as the second half of a split load
  always_ff @(posedge lq_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_line  <= '0;
      entry_bytes <= '0;
      entry_iid   <= '0;
      entry_secd  <= 1'b0;
    end
    else if (create0_dp_vld)
    begin
      entry_line  <= ld_addr0[PA_WIDTH-1:LINE_OFFS];
      entry_bytes <= ld_bytes_vld;
      entry_iid   <= ld_iid;
      entry_secd  <= ld_secd;
    end
    else if (create1_dp_vld)
    begin
      entry_line  <= ld_addr1[PA_WIDTH-1:LINE_OFFS];
      entry_bytes <= ld_bytes_vld1;
      entry_iid   <= ld_iid;
      // second half always marked
      entry_secd  <= 1'b1;
    end
  end

  //======================================================================
  // commit release
  //======================================================================
  // any of the three retire ports naming this id
  assign cmit_hit0 = commit0 && (commit0_iid == entry_iid);
  assign cmit_hit1 = commit1 && (commit1_iid == entry_iid);
  assign cmit_hit2 = commit2 && (commit2_iid == entry_iid);

  assign pop_vld   = entry_vld && (cmit_hit0 || cmit_hit1 || cmit_hit2);

  // load in the pipe already owns this entry
  assign inst_hit  = entry_vld
                     && (entry_secd == ld_secd)
                     && (entry_iid == ld_iid);

  // contents out to the checkers
  assign ent.vld   = entry_vld;
  assign ent.iid   = entry_iid;
  assign ent.secd  = entry_secd;
  assign ent.line  = entry_line;
  assign ent.bytes = entry_bytes;

endmodule

/* design/lq_rar_check.sv */
// read after read speculation check
// flags an older pipe load reading bytes this newer entry already read
`timescale 1ns/100ps

module lq_rar_check #(
  parameter int PA_WIDTH = 40
) (
  input  logic                ld_inst_chk_vld,
  input  logic                ld_chk_addr1_vld,
  input  logic [PA_WIDTH-1:0] ld_addr0,
  input  logic [PA_WIDTH-1:0] ld_addr1,
  input  lq_pkg::bytes_t      ld_bytes_vld,
  input  lq_pkg::bytes_t      ld_bytes_vld1,
  input  lq_pkg::iid_t        ld_iid,
  input  logic                corr_dis,
  lq_entry_if.check           ent,
  output logic                rar_spec_fail
);
  import lq_pkg::*;

  logic ent_newer;
  logic addr0_hit;
  logic addr1_hit;
  logic bytes0_hit;
  logic bytes1_hit;
  logic fail0;
  logic fail1;

  //======================================================================
  // compare
  //======================================================================
  // pipe load older than the queued one
  assign ent_newer  = ent.vld && iid_older(ld_iid, ent.iid);

  // line index match on both pipe addresses
  assign addr0_hit  = (ent.line == ld_addr0[PA_WIDTH-1:LINE_OFFS]);
  assign addr1_hit  = (ent.line == ld_addr1[PA_WIDTH-1:LINE_OFFS]);

  // any byte in common
  assign bytes0_hit = |(ent.bytes & ld_bytes_vld);
  assign bytes1_hit = |(ent.bytes & ld_bytes_vld1);

  // case 0 on the primary address
  assign fail0 = ent_newer && ld_inst_chk_vld && addr0_hit && bytes0_hit;
  // case 1 on the cross line second address
  assign fail1 = ent_newer && ld_chk_addr1_vld && addr1_hit && bytes1_hit;

  // check can be turned off
  assign rar_spec_fail = (fail0 || fail1) && !corr_dis;

endmodule

/* design/lq_raw_check.sv */
// read after write speculation check
// flags an older store writing bytes this newer entry already read
`timescale 1ns/100ps

module lq_raw_check #(
  parameter int PA_WIDTH = 40
) (
  input  logic [PA_WIDTH-1:0] st_addr0,
  input  lq_pkg::bytes_t      st_bytes_vld,
  input  lq_pkg::iid_t        st_iid,
  input  logic                st_chk_st_vld,
  input  logic                st_chk_statomic_vld,
  lq_entry_if.check           ent,
  output logic                raw_spec_fail
);
  import lq_pkg::*;

  logic ent_newer;
  logic st_chk_vld;
  logic addr_hit;
  logic bytes_hit;

  // store older than the queued load
  assign ent_newer  = ent.vld && iid_older(st_iid, ent.iid);

  // plain store or store atomic both checked
  assign st_chk_vld = st_chk_st_vld || st_chk_statomic_vld;

  assign addr_hit   = (ent.line == st_addr0[PA_WIDTH-1:LINE_OFFS]);
  assign bytes_hit  = |(ent.bytes & st_bytes_vld);

  // no corr_dis mask here
  assign raw_spec_fail = ent_newer && st_chk_vld && addr_hit && bytes_hit;

endmodule

/* design/lq_entry.sv */
// load queue entry
// one queued load with commit release, instance hit and
// read after read / read after write speculation checks
`timescale 1ns/100ps

module lq_entry #(
  parameter int PA_WIDTH = 40
) (
  input  logic                lq_clk,
  input  logic                cpurst_b,
  input  logic                create0_vld,
  input  logic                create1_vld,
  input  logic                create0_dp_vld,
  input  logic                create1_dp_vld,
  input  logic [PA_WIDTH-1:0] ld_addr0,
  input  logic [PA_WIDTH-1:0] ld_addr1,
  input  lq_pkg::bytes_t      ld_bytes_vld,
  input  lq_pkg::bytes_t      ld_bytes_vld1,
  input  lq_pkg::iid_t        ld_iid,
  input  logic                ld_secd,
  input  logic                ld_inst_chk_vld,
  input  logic                ld_chk_addr1_vld,
  input  logic                corr_dis,
  input  logic                commit0,
  input  logic                commit1,
  input  logic                commit2,
  input  lq_pkg::iid_t        commit0_iid,
  input  lq_pkg::iid_t        commit1_iid,
  input  lq_pkg::iid_t        commit2_iid,
  input  logic                flush,
  input  logic [PA_WIDTH-1:0] st_addr0,
  input  lq_pkg::bytes_t      st_bytes_vld,
  input  lq_pkg::iid_t        st_iid,
  input  logic                st_chk_st_vld,
  input  logic                st_chk_statomic_vld,
  output logic                vld,
  output logic                inst_hit,
  output logic                rar_spec_fail,
  output logic                raw_spec_fail
);

  //======================================================================
  // entry contents bus
  //======================================================================
  lq_entry_if #(.PA_WIDTH(PA_WIDTH)) ent_if ();

  assign vld = ent_if.vld;

  //======================================================================
  // storage
  //======================================================================
  lq_entry_store #(.PA_WIDTH(PA_WIDTH)) store_i (
    .lq_clk         (lq_clk),
    .cpurst_b       (cpurst_b),
    .create0_vld    (create0_vld),
    .create1_vld    (create1_vld),
    .create0_dp_vld (create0_dp_vld),
    .create1_dp_vld (create1_dp_vld),
    .ld_addr0       (ld_addr0),
    .ld_addr1       (ld_addr1),
    .ld_bytes_vld   (ld_bytes_vld),
    .ld_bytes_vld1  (ld_bytes_vld1),
    .ld_iid         (ld_iid),
    .ld_secd        (ld_secd),
    .commit0        (commit0),
    .commit1        (commit1),
    .commit2        (commit2),
    .commit0_iid    (commit0_iid),
    .commit1_iid    (commit1_iid),
    .commit2_iid    (commit2_iid),
    .flush          (flush),
    .inst_hit       (inst_hit),
    .ent            (ent_if.store)
  );

  //======================================================================
  // speculation checks
  //======================================================================
  lq_rar_check #(.PA_WIDTH(PA_WIDTH)) rar_i (
    .ld_inst_chk_vld  (ld_inst_chk_vld),
    .ld_chk_addr1_vld (ld_chk_addr1_vld),
    .ld_addr0         (ld_addr0),
    .ld_addr1         (ld_addr1),
    .ld_bytes_vld     (ld_bytes_vld),
    .ld_bytes_vld1    (ld_bytes_vld1),
    .ld_iid           (ld_iid),
    .corr_dis         (corr_dis),
    .ent              (ent_if.check),
    .rar_spec_fail    (rar_spec_fail)
  );

  // store pipe side
  lq_raw_check #(.PA_WIDTH(PA_WIDTH)) raw_i (
    .st_addr0            (st_addr0),
    .st_bytes_vld        (st_bytes_vld),
    .st_iid              (st_iid),
    .st_chk_st_vld       (st_chk_st_vld),
    .st_chk_statomic_vld (st_chk_statomic_vld),
    .ent                 (ent_if.check),
    .raw_spec_fail       (raw_spec_fail)
  );

endmodule

/* verif/lq_entry_props.sv */
// load queue entry protocol checks
// bound into the entry top level, covers reset, flush and check masking
`timescale 1ns/100ps

module lq_entry_props (
  input logic lq_clk,
  input logic cpurst_b,
  input logic flush,
  input logic corr_dis,
  input logic vld,
  input logic inst_hit,
  input logic rar_spec_fail,
  input logic raw_spec_fail
);

  // failures seen so far
  int fail_cnt = 0;

  //======================================================================
  // properties
  //======================================================================
  // everything quiet while reset is held
  a_reset_quiet: assert property (@(posedge lq_clk)
    !cpurst_b |-> !(vld || inst_hit || rar_spec_fail || raw_spec_fail))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("output high while reset is asserted");
  end

  // flush empties the entry one edge later
  a_flush_clear: assert property (@(posedge lq_clk) disable iff (!cpurst_b)
    flush |=> !vld)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("entry still valid after a flush");
  end

  // rar masked off, or nothing to compare
  a_rar_quiet: assert property (@(posedge lq_clk) disable iff (!cpurst_b)
    (corr_dis || !vld) |-> !rar_spec_fail)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("rar_spec_fail high with corr_dis set or entry empty");
  end

  // raw needs a live entry
  a_raw_quiet: assert property (@(posedge lq_clk) disable iff (!cpurst_b)
    !vld |-> !raw_spec_fail)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("raw_spec_fail high with entry empty");
  end

endmodule

bind lq_entry lq_entry_props props_i (.*);

/* verif/lq_entry_tb.sv */
// load queue entry testbench
// random load, store, commit and flush traffic checked against a reference model
`timescale 1ns/100ps

module lq_entry_tb;
  import lq_pkg::*;

  localparam int PA_WIDTH = 40;
  localparam int LINE_W   = PA_WIDTH - LINE_OFFS;
  localparam int NUM_COV  = 14;
  localparam int TIMEOUT  = 3000;

  logic                lq_clk;
  logic                cpurst_b;
  logic                create0_vld;
  logic                create1_vld;
  logic                create0_dp_vld;
  logic                create1_dp_vld;
  logic [PA_WIDTH-1:0] ld_addr0;
  logic [PA_WIDTH-1:0] ld_addr1;
  bytes_t              ld_bytes_vld;
  bytes_t              ld_bytes_vld1;
  iid_t                ld_iid;
  logic                ld_secd;
  logic                ld_inst_chk_vld;
  logic                ld_chk_addr1_vld;
  logic                corr_dis;
  logic                commit0;
  logic                commit1;
  logic                commit2;
  iid_t                commit0_iid;
  iid_t                commit1_iid;
  iid_t                commit2_iid;
  logic                flush;
  logic [PA_WIDTH-1:0] st_addr0;
  bytes_t              st_bytes_vld;
  iid_t                st_iid;
  logic                st_chk_st_vld;
  logic                st_chk_statomic_vld;
  logic                vld;
  logic                inst_hit;
  logic                rar_spec_fail;
  logic                raw_spec_fail;

  // reference model state
  logic                m_vld;
  iid_t                m_iid;
  logic                m_secd;
  logic [LINE_W-1:0]   m_line;
  bytes_t              m_bytes;
  logic                m_slot1;
  logic                m_pop;
  logic                exp_inst_hit;
  logic                rar0_hit;
  logic                rar1_hit;
  logic                exp_rar;
  logic                exp_raw;
  logic                covered [NUM_COV];

  lq_entry #(.PA_WIDTH(PA_WIDTH)) dut_i (.*);

  initial lq_clk = 1'b0;
  always #10 lq_clk = ~lq_clk;

  // a before b, wrap flag flips the sequence order
  function automatic logic id_before(input iid_t a, input iid_t b);
    if (a[IID_W-1] == b[IID_W-1])
      return a[IID_W-2:0] < b[IID_W-2:0];
    return a[IID_W-2:0] > b[IID_W-2:0];
  endfunction

  // few ids on both sides of the wrap
  function automatic iid_t pick_iid();
    logic [IID_W-2:0] seq;
    case ($urandom_range(3))
      0:       seq = 6'd0;
      1:       seq = 6'd1;
      2:       seq = 6'd62;
      default: seq = 6'd63;
    endcase
    return {1'($urandom_range(1)), seq};
  endfunction

  // two neighbouring lines, any offset
  function automatic logic [PA_WIDTH-1:0] addr_from_set();
    logic [LINE_W-1:0] line;
    line = LINE_W'('h1234567) + LINE_W'($urandom_range(1));
    return {line, LINE_OFFS'($urandom)};
  endfunction

  function automatic bytes_t sparse_mask();
    return bytes_t'($urandom & $urandom);
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_mismatch(input string name, input logic got, input logic want);
    $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, want);
    stop_with_failure();
  endtask

  //======================================================================
  // stimulus
  //======================================================================
  task automatic drive_random();
    logic c0;
    logic c1;
    c0 = ($urandom_range(3) == 0);
    // both slots together now and then, slot 0 data wins
    c1 = ($urandom_range(5) == 0);
    create0_vld         <= c0;
    create1_vld         <= c1;
    create0_dp_vld      <= c0;
    create1_dp_vld      <= c1;
    ld_addr0            <= addr_from_set();
    ld_addr1            <= addr_from_set();
    ld_bytes_vld        <= sparse_mask();
    ld_bytes_vld1       <= sparse_mask();
    ld_iid              <= pick_iid();
    ld_secd             <= 1'($urandom_range(1));
    ld_inst_chk_vld     <= 1'($urandom_range(1));
    ld_chk_addr1_vld    <= 1'($urandom_range(1));
    corr_dis            <= ($urandom_range(3) == 0);
    commit0             <= ($urandom_range(7) == 0);
    commit1             <= ($urandom_range(7) == 0);
    commit2             <= ($urandom_range(7) == 0);
    commit0_iid         <= pick_iid();
    commit1_iid         <= pick_iid();
    commit2_iid         <= pick_iid();
    flush               <= ($urandom_range(31) == 0);
    st_addr0            <= addr_from_set();
    st_bytes_vld        <= sparse_mask();
    st_iid              <= pick_iid();
    st_chk_st_vld       <= 1'($urandom_range(1));
    st_chk_statomic_vld <= 1'($urandom_range(1));
  endtask

  //======================================================================
  // reference model
  //======================================================================
  assign m_pop = m_vld && ((commit0 && commit0_iid == m_iid)
                           || (commit1 && commit1_iid == m_iid)
                           || (commit2 && commit2_iid == m_iid));

  always @(posedge lq_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      m_vld   <= 1'b0;
      m_iid   <= '0;
      m_secd  <= 1'b0;
      m_line  <= '0;
      m_bytes <= '0;
      m_slot1 <= 1'b0;
    end
    else
    begin
      // release before allocate
      if (m_pop || flush)
        m_vld <= 1'b0;
      else if (create0_vld || create1_vld)
        m_vld <= 1'b1;
      if (create0_dp_vld)
      begin
        m_iid   <= ld_iid;
        m_secd  <= ld_secd;
        m_line  <= ld_addr0[PA_WIDTH-1:LINE_OFFS];
        m_bytes <= ld_bytes_vld;
        m_slot1 <= 1'b0;
      end
      else if (create1_dp_vld)
      begin
        m_iid   <= ld_iid;
        m_secd  <= 1'b1;
        m_line  <= ld_addr1[PA_WIDTH-1:LINE_OFFS];
        m_bytes <= ld_bytes_vld1;
        m_slot1 <= 1'b1;
      end
    end
  end

  assign exp_inst_hit = m_vld && (ld_iid == m_iid) && (ld_secd == m_secd);
  // rar cases before the corr_dis mask
  assign rar0_hit = m_vld && id_before(ld_iid, m_iid) && ld_inst_chk_vld
                    && (ld_addr0[PA_WIDTH-1:LINE_OFFS] == m_line)
                    && ((ld_bytes_vld & m_bytes) != '0);
  assign rar1_hit = m_vld && id_before(ld_iid, m_iid) && ld_chk_addr1_vld
                    && (ld_addr1[PA_WIDTH-1:LINE_OFFS] == m_line)
                    && ((ld_bytes_vld1 & m_bytes) != '0);
  assign exp_rar  = (rar0_hit || rar1_hit) && !corr_dis;
  assign exp_raw  = m_vld && id_before(st_iid, m_iid)
                    && (st_chk_st_vld || st_chk_statomic_vld)
                    && (st_addr0[PA_WIDTH-1:LINE_OFFS] == m_line)
                    && ((st_bytes_vld & m_bytes) != '0);

  //======================================================================
  // checks
  //======================================================================
  a_vld: assert property (@(posedge lq_clk) disable iff (!cpurst_b) vld == m_vld)
    else value_mismatch("vld", $sampled(vld), $sampled(m_vld));
  a_inst_hit: assert property (@(posedge lq_clk) disable iff (!cpurst_b)
                               inst_hit == exp_inst_hit)
    else value_mismatch("inst_hit", $sampled(inst_hit), $sampled(exp_inst_hit));
  a_rar: assert property (@(posedge lq_clk) disable iff (!cpurst_b) rar_spec_fail == exp_rar)
    else value_mismatch("rar_spec_fail", $sampled(rar_spec_fail), $sampled(exp_rar));
  a_raw: assert property (@(posedge lq_clk) disable iff (!cpurst_b) raw_spec_fail == exp_raw)
    else value_mismatch("raw_spec_fail", $sampled(raw_spec_fail), $sampled(exp_raw));

  // bound checker failures
  always @(posedge lq_clk)
  begin
    if (dut_i.props_i.fail_cnt != 0)
    begin
      $display("a bound property of the entry failed at %0t", $time);
      stop_with_failure();
    end
  end

  // coverage of each behavior, sampled before the edge
  always @(posedge lq_clk)
  begin
    if (cpurst_b)
    begin
      if (exp_inst_hit && !m_slot1) covered[0] <= 1'b1;
      if (exp_inst_hit && m_slot1) covered[1] <= 1'b1;
      if (m_vld && commit0 && commit0_iid == m_iid) covered[2] <= 1'b1;
      if (m_vld && commit1 && commit1_iid == m_iid) covered[3] <= 1'b1;
      if (m_vld && commit2 && commit2_iid == m_iid) covered[4] <= 1'b1;
      if (m_vld && flush) covered[5] <= 1'b1;
      if ((m_pop || flush) && (create0_vld || create1_vld)) covered[6] <= 1'b1;
      if (rar0_hit && !corr_dis) covered[7] <= 1'b1;
      if (rar1_hit && !corr_dis) covered[8] <= 1'b1;
      if (exp_rar && (ld_iid[IID_W-1] != m_iid[IID_W-1])) covered[9] <= 1'b1;
      if ((rar0_hit || rar1_hit) && corr_dis) covered[10] <= 1'b1;
      if (exp_raw && st_chk_st_vld && !st_chk_statomic_vld) covered[11] <= 1'b1;
      if (exp_raw && st_chk_statomic_vld && !st_chk_st_vld) covered[12] <= 1'b1;
      if (exp_raw && corr_dis) covered[13] <= 1'b1;
    end
  end

  // keep traffic running until item idx is seen
  task automatic wait_covered(input int idx);
    int cycles;
    cycles = 0;
    while (!covered[idx])
    begin
      if (cycles == TIMEOUT)
      begin
        $display("timeout: behavior %0d never seen in %0d cycles", idx, TIMEOUT);
        stop_with_failure();
      end
      @(posedge lq_clk);
      drive_random();
      cycles++;
    end
  endtask

  //======================================================================
  // main sequence
  //======================================================================
  initial
  begin
    void'($urandom(15638));
    foreach (covered[i])
      covered[i] <= 1'b0;
    cpurst_b            <= 1'b0;
    create0_vld         <= 1'b0;
    create1_vld         <= 1'b0;
    create0_dp_vld      <= 1'b0;
    create1_dp_vld      <= 1'b0;
    ld_addr0            <= '0;
    ld_addr1            <= '0;
    ld_bytes_vld        <= '0;
    ld_bytes_vld1       <= '0;
    ld_iid              <= '0;
    ld_secd             <= 1'b0;
    ld_inst_chk_vld     <= 1'b0;
    ld_chk_addr1_vld    <= 1'b0;
    corr_dis            <= 1'b0;
    commit0             <= 1'b0;
    commit1             <= 1'b0;
    commit2             <= 1'b0;
    commit0_iid         <= '0;
    commit1_iid         <= '0;
    commit2_iid         <= '0;
    flush               <= 1'b0;
    st_addr0            <= '0;
    st_bytes_vld        <= '0;
    st_iid              <= '0;
    st_chk_st_vld       <= 1'b0;
    st_chk_statomic_vld <= 1'b0;
    repeat (4) @(posedge lq_clk);
    cpurst_b <= 1'b1;
    for (int i = 0; i < NUM_COV; i++)
      wait_covered(i);
    repeat (2) @(posedge lq_clk);
    if (dut_i.props_i.fail_cnt == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("a bound property of the entry failed");
      stop_with_failure();
    end
  end

endmodule

/* project.f */
design/lq_pkg.sv
design/lq_entry_if.sv
design/lq_entry_store.sv
design/lq_rar_check.sv
design/lq_raw_check.sv
design/lq_entry.sv
verif/lq_entry_props.sv
verif/lq_entry_tb.sv

/* Bender.yml */
package:
  name: lq_entry

sources:
  - files:
      - design/lq_pkg.sv
      - design/lq_entry_if.sv
      - design/lq_entry_store.sv
      - design/lq_rar_check.sv
      - design/lq_raw_check.sv
      - design/lq_entry.sv
  - target: simulation
    files:
      - verif/lq_entry_props.sv
      - verif/lq_entry_tb.sv
